//--- source/fetch_pkg.sv
package fetch_pkg;

  // datapath and sequencing widths
  localparam int XLEN    = 32;
  localparam int ORDER_W = 64;

  // queue geometry
  localparam int IQ_DEPTH_LOG2 = 3;
  localparam int IQ_DEPTH      = 2 ** IQ_DEPTH_LOG2;

  // first fetch address out of reset
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;

  // major opcodes of the base integer set
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    SYSTEM = 7'b1110011
  } rv_opcode_e;

  // one queue slot, pc side written at reservation and instr side at fill
  typedef struct packed {
    logic [XLEN-1:0]    pc;
    logic [XLEN-1:0]    pc_next;
    logic [ORDER_W-1:0] order;
    logic [XLEN-1:0]    instr;
    logic               fault;
  } iq_entry_t;

endpackage : fetch_pkg

//--- source/iq_ifs.sv
`timescale 1ns/100ps

// slot reservation from fetch into the queue
interface iq_alloc_if;
  import fetch_pkg::*;

  logic               alloc_valid;
  logic [XLEN-1:0]    alloc_pc;
  logic [XLEN-1:0]    alloc_pc_next;
  logic [ORDER_W-1:0] alloc_order;
  logic               full;

  modport producer (output alloc_valid, alloc_pc, alloc_pc_next, alloc_order, input full);
  modport buffer (input alloc_valid, alloc_pc, alloc_pc_next, alloc_order, output full);

endinterface : iq_alloc_if

// oldest complete entry toward decode
interface iq_issue_if;
  import fetch_pkg::*;

  logic      valid;
  iq_entry_t entry;
  logic      ready;

  modport buffer (output valid, entry, input ready);
  modport consumer (input valid, entry, output ready);

endinterface : iq_issue_if

//--- source/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       flush,
  input  logic [fetch_pkg::XLEN-1:0] flush_pc,
  output logic [fetch_pkg::XLEN-1:0] imem_araddr,
  output logic                       imem_arvalid,
  input  logic                       imem_arready,
  input  logic [fetch_pkg::XLEN-1:0] imem_rdata,
  input  logic [1:0]                 imem_rresp,
  input  logic                       imem_rvalid,
  output logic                       imem_rready,
  iq_alloc_if.producer               alloc,
  output logic                       fill_valid,
  output logic [fetch_pkg::XLEN-1:0] fill_instr,
  output logic                       fill_fault
);
  import fetch_pkg::*;

  logic [XLEN-1:0]          pc;
  logic [XLEN-1:0]          redirect_pc;
  logic                     redirect_pend;
  logic [ORDER_W-1:0]       order;
  logic [IQ_DEPTH_LOG2+1:0] out_cnt;
  logic [IQ_DEPTH_LOG2+1:0] out_next;
  logic [IQ_DEPTH_LOG2+1:0] drop_cnt;
  logic                     run;
  logic                     ar_hs;
  logic                     ar_stall;
  logic                     r_hs;

  // request only while a slot is free; neither term can fall before the handshake
  assign imem_arvalid = run && !alloc.full && (out_cnt != '1);
  assign imem_araddr  = pc;
  assign imem_rready  = 1'b1;

  assign ar_hs    = imem_arvalid && imem_arready;
  assign ar_stall = imem_arvalid && !imem_arready;
  assign r_hs     = imem_rvalid && imem_rready;

  // an address accepted after a redirect belongs to the old stream, no slot for it
  assign alloc.alloc_valid   = ar_hs && !redirect_pend;
  assign alloc.alloc_pc      = pc;
  assign alloc.alloc_pc_next = pc + XLEN'(4);
  assign alloc.alloc_order   = order;

  assign fill_valid = r_hs && (drop_cnt == '0);
  assign fill_instr = imem_rdata;
  assign fill_fault = (imem_rresp != 2'b00);

  // reads in flight after this edge
  always_comb begin
    out_next = out_cnt;
    if (ar_hs) begin
      out_next = out_next + 1'b1;
    end
    if (r_hs) begin
      out_next = out_next - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run           <= 1'b0;
      pc            <= RESET_PC;
      order         <= '0;
      out_cnt       <= '0;
      drop_cnt      <= '0;
      redirect_pend <= 1'b0;
    end else begin
      run     <= 1'b1;
      out_cnt <= out_next;
      if (alloc.alloc_valid) begin
        order <= order + 1'b1;
      end
      if (flush) begin
        // everything still out, a stalled address included, comes back as garbage
        drop_cnt      <= ar_stall ? out_next + 1'b1 : out_next;
        redirect_pend <= ar_stall;
        if (!ar_stall) begin
          pc <= flush_pc;
        end
      end else begin
        if (r_hs && (drop_cnt != '0)) begin
          drop_cnt <= drop_cnt - 1'b1;
        end
        if (ar_hs) begin
          redirect_pend <= 1'b0;
          pc            <= redirect_pend ? redirect_pc : pc + XLEN'(4);
        end
      end
    end
  end

  // target kept until the stalled address is accepted
  always_ff @(posedge clk) begin
    if (flush && ar_stall) begin
      redirect_pc <= flush_pc;
    end
  end

  a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
    imem_arvalid && !imem_arready |=> imem_arvalid && $stable(imem_araddr));

  a_no_stray_resp: assert property (@(posedge clk) disable iff (!arst_n)
    imem_rvalid |-> out_cnt != '0);

endmodule : fetch_unit

//--- source/instruction_queue.sv
`timescale 1ns/100ps

module instruction_queue (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       flush,
  iq_alloc_if.buffer                 alloc,
  input  logic                       fill_valid,
  input  logic [fetch_pkg::XLEN-1:0] fill_instr,
  input  logic                       fill_fault,
  iq_issue_if.buffer                 issue
);
  import fetch_pkg::*;

  iq_entry_t                slots [IQ_DEPTH];
  logic [IQ_DEPTH-1:0]      reserved;
  logic [IQ_DEPTH-1:0]      filled;
  logic [IQ_DEPTH_LOG2-1:0] res_head;
  logic [IQ_DEPTH_LOG2-1:0] fill_head;
  logic [IQ_DEPTH_LOG2-1:0] tail;
  logic                     pop;

  // the next slot to reserve still holds an older entry
  assign alloc.full = reserved[res_head];

  assign issue.valid = filled[tail];
  assign issue.entry = slots[tail];
  assign pop         = issue.valid && issue.ready;

  // reserve, fill and pop never touch the same slot in one cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reserved  <= '0;
      filled    <= '0;
      res_head  <= '0;
      fill_head <= '0;
      tail      <= '0;
    end else if (flush) begin
      reserved  <= '0;
      filled    <= '0;
      res_head  <= '0;
      fill_head <= '0;
      tail      <= '0;
    end else begin
      if (alloc.alloc_valid) begin
        reserved[res_head] <= 1'b1;
        res_head           <= res_head + 1'b1;
      end
      if (fill_valid) begin
        filled[fill_head] <= 1'b1;
        fill_head         <= fill_head + 1'b1;
      end
      if (pop) begin
        reserved[tail] <= 1'b0;
        filled[tail]   <= 1'b0;
        tail           <= tail + 1'b1;
      end
    end
  end

  // slot payload
  always_ff @(posedge clk) begin
    if (alloc.alloc_valid) begin
      slots[res_head].pc      <= alloc.alloc_pc;
      slots[res_head].pc_next <= alloc.alloc_pc_next;
      slots[res_head].order   <= alloc.alloc_order;
    end
    if (fill_valid) begin
      slots[fill_head].instr <= fill_instr;
      slots[fill_head].fault <= fill_fault;
    end
  end

  // responses come back in address order, so the fill slot must be waiting
  a_fill_has_slot: assert property (@(posedge clk) disable iff (!arst_n)
    fill_valid |-> reserved[fill_head] && !filled[fill_head]);

  a_no_alloc_full: assert property (@(posedge clk) disable iff (!arst_n)
    alloc.alloc_valid |-> !alloc.full);

endmodule : instruction_queue

//--- source/rv32_decode.sv
`timescale 1ns/100ps

module rv32_decode (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          flush,
  iq_issue_if.consumer                  issue,
  output logic                          issue_valid,
  input  logic                          issue_ready,
  output logic [fetch_pkg::XLEN-1:0]    issue_pc,
  output logic [fetch_pkg::XLEN-1:0]    issue_pc_next,
  output logic [fetch_pkg::ORDER_W-1:0] issue_order,
  output logic [fetch_pkg::XLEN-1:0]    issue_instr,
  output logic                          issue_fault,
  output fetch_pkg::rv_opcode_e         issue_opcode,
  output logic [2:0]                    issue_funct3,
  output logic [6:0]                    issue_funct7,
  output logic [fetch_pkg::XLEN-1:0]    issue_imm,
  output logic [4:0]                    issue_rs1,
  output logic [4:0]                    issue_rs2,
  output logic [4:0]                    issue_rd
);
  import fetch_pkg::*;

  iq_entry_t       entry_q;
  logic [XLEN-1:0] instr;
  logic [XLEN-1:0] imm;
  rv_opcode_e      opcode;
  logic            take;

  // accept when empty or when the current word leaves this cycle
  assign issue.ready = !issue_valid || issue_ready;
  assign take        = issue.valid && issue.ready;

  assign instr  = issue.entry.instr;
  assign opcode = rv_opcode_e'(instr[6:0]);

  // immediate format follows the opcode
  always_comb begin
    case (opcode)
      LOAD, OP_IMM, JALR, SYSTEM:
        imm = {{20{instr[31]}}, instr[31:20]};
      STORE:
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      BRANCH:
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      LUI, AUIPC:
        imm = {instr[31:12], 12'h000};
      JAL:
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      default:
        imm = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      issue_valid <= 1'b0;
    end else if (flush) begin
      issue_valid <= 1'b0;
    end else if (take) begin
      issue_valid <= 1'b1;
    end else if (issue_ready) begin
      issue_valid <= 1'b0;
    end
  end

  // fields are split once, at capture
  always_ff @(posedge clk) begin
    if (take) begin
      entry_q      <= issue.entry;
      issue_opcode <= opcode;
      issue_funct3 <= instr[14:12];
      issue_funct7 <= instr[31:25];
      issue_rs1    <= instr[19:15];
      issue_rs2    <= instr[24:20];
      issue_rd     <= instr[11:7];
      issue_imm    <= imm;
    end
  end

  assign issue_pc      = entry_q.pc;
  assign issue_pc_next = entry_q.pc_next;
  assign issue_order   = entry_q.order;
  assign issue_instr   = entry_q.instr;
  assign issue_fault   = entry_q.fault;

  a_issue_hold: assert property (@(posedge clk) disable iff (!arst_n)
    issue_valid && !issue_ready && !flush |=>
      issue_valid && $stable(entry_q) && $stable(issue_imm) && $stable(issue_opcode));

endmodule : rv32_decode

//--- source/fetch_top.sv
`timescale 1ns/100ps

module fetch_top (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          flush,
  input  logic [fetch_pkg::XLEN-1:0]    flush_pc,
  // instruction memory, AXI4-Lite read
  output logic [fetch_pkg::XLEN-1:0]    imem_araddr,
  output logic                          imem_arvalid,
  input  logic                          imem_arready,
  input  logic [fetch_pkg::XLEN-1:0]    imem_rdata,
  input  logic [1:0]                    imem_rresp,
  input  logic                          imem_rvalid,
  output logic                          imem_rready,
  // decoded instruction out
  output logic                          issue_valid,
  input  logic                          issue_ready,
  output logic [fetch_pkg::XLEN-1:0]    issue_pc,
  output logic [fetch_pkg::XLEN-1:0]    issue_pc_next,
  output logic [fetch_pkg::ORDER_W-1:0] issue_order,
  output logic [fetch_pkg::XLEN-1:0]    issue_instr,
  output logic                          issue_fault,
  output fetch_pkg::rv_opcode_e         issue_opcode,
  output logic [2:0]                    issue_funct3,
  output logic [6:0]                    issue_funct7,
  output logic [fetch_pkg::XLEN-1:0]    issue_imm,
  output logic [4:0]                    issue_rs1,
  output logic [4:0]                    issue_rs2,
  output logic [4:0]                    issue_rd
);
  import fetch_pkg::*;

  logic            fill_valid;
  logic [XLEN-1:0] fill_instr;
  logic            fill_fault;

  iq_alloc_if alloc_if ();
  iq_issue_if issue_if ();

  fetch_unit u_fetch (
    .clk          (clk),
    .arst_n       (arst_n),
    .flush        (flush),
    .flush_pc     (flush_pc),
    .imem_araddr  (imem_araddr),
    .imem_arvalid (imem_arvalid),
    .imem_arready (imem_arready),
    .imem_rdata   (imem_rdata),
    .imem_rresp   (imem_rresp),
    .imem_rvalid  (imem_rvalid),
    .imem_rready  (imem_rready),
    .alloc        (alloc_if.producer),
    .fill_valid   (fill_valid),
    .fill_instr   (fill_instr),
    .fill_fault   (fill_fault)
  );

  instruction_queue u_iq (
    .clk        (clk),
    .arst_n     (arst_n),
    .flush      (flush),
    .alloc      (alloc_if.buffer),
    .fill_valid (fill_valid),
    .fill_instr (fill_instr),
    .fill_fault (fill_fault),
    .issue      (issue_if.buffer)
  );

  rv32_decode u_dec (
    .clk           (clk),
    .arst_n        (arst_n),
    .flush         (flush),
    .issue         (issue_if.consumer),
    .issue_valid   (issue_valid),
    .issue_ready   (issue_ready),
    .issue_pc      (issue_pc),
    .issue_pc_next (issue_pc_next),
    .issue_order   (issue_order),
    .issue_instr   (issue_instr),
    .issue_fault   (issue_fault),
    .issue_opcode  (issue_opcode),
    .issue_funct3  (issue_funct3),
    .issue_funct7  (issue_funct7),
    .issue_imm     (issue_imm),
    .issue_rs1     (issue_rs1),
    .issue_rs2     (issue_rs2),
    .issue_rd      (issue_rd)
  );

endmodule : fetch_top

//--- tb/tb_imem_axil.sv
`timescale 1ns/100ps

module tb_imem_axil (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic [fetch_pkg::XLEN-1:0] words [16],
  input  logic [fetch_pkg::XLEN-1:0] araddr,
  input  logic                       arvalid,
  output logic                       arready,
  output logic [fetch_pkg::XLEN-1:0] rdata,
  output logic [1:0]                 rresp,
  output logic                       rvalid,
  input  logic                       rready
);
  import fetch_pkg::*;

  logic [XLEN-1:0] pend_q [$];
  logic [XLEN-1:0] addr_s;
  logic [XLEN-1:0] addr_r;
  logic            ar_fire;
  logic            r_fire;
  int              ar_wait;
  int              r_wait;

  initial begin
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    rresp   = 2'b00;
    ar_wait = 0;
    r_wait  = 0;
  end

  // sample at the edge, drive 10 ns later
  always begin
    @(posedge clk);
    ar_fire = arvalid && arready;
    r_fire  = rvalid && rready;
    addr_s  = araddr;
    #10;
    if (!arst_n) begin
      arready = 1'b0;
      rvalid  = 1'b0;
      pend_q.delete();
    end else begin
      if (ar_fire) begin
        pend_q.push_back(addr_s);
        ar_wait = $urandom_range(0, 3);
      end
      if (ar_wait > 0) begin
        arready = 1'b0;
        ar_wait--;
      end else begin
        arready = 1'b1;
      end
      if (r_fire) begin
        rvalid = 1'b0;
      end
      // responses leave in the order the addresses came in
      if (!rvalid && pend_q.size() > 0) begin
        if (r_wait > 0) begin
          r_wait--;
        end else begin
          addr_r = pend_q.pop_front();
          rvalid = 1'b1;
          if (addr_r >= 32'h0000_2000) begin
            rdata = '0;
            rresp = 2'b10;
          end else begin
            rdata = words[((addr_r - RESET_PC) >> 2) & 15];
            rresp = 2'b00;
          end
          r_wait = $urandom_range(0, 3);
        end
      end
    end
  end

endmodule : tb_imem_axil

//--- tb/tb_fetch_top.sv
`timescale 1ns/100ps

module tb_fetch_top;
  import fetch_pkg::*;

  // one row: word, opcode, funct3, funct7, imm, rs1, rs2, rd
  typedef struct packed {
    logic [31:0] word;
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] imm;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
  } row_t;

  logic               clk;
  logic               arst_n;
  logic               flush;
  logic [XLEN-1:0]    flush_pc;
  logic [XLEN-1:0]    imem_araddr;
  logic               imem_arvalid;
  logic               imem_arready;
  logic [XLEN-1:0]    imem_rdata;
  logic [1:0]         imem_rresp;
  logic               imem_rvalid;
  logic               imem_rready;
  logic               issue_valid;
  logic               issue_ready;
  logic [XLEN-1:0]    issue_pc;
  logic [XLEN-1:0]    issue_pc_next;
  logic [ORDER_W-1:0] issue_order;
  logic [XLEN-1:0]    issue_instr;
  logic               issue_fault;
  rv_opcode_e         issue_opcode;
  logic [2:0]         issue_funct3;
  logic [6:0]         issue_funct7;
  logic [XLEN-1:0]    issue_imm;
  logic [4:0]         issue_rs1;
  logic [4:0]         issue_rs2;
  logic [4:0]         issue_rd;

  row_t               tbl [16];
  logic [XLEN-1:0]    imem_words [16];
  logic [ORDER_W-1:0] last_ord;
  logic [XLEN-1:0]    next_pc;
  logic [XLEN-1:0]    snap_pc;
  logic [ORDER_W-1:0] snap_ord;
  logic [XLEN-1:0]    snap_instr;
  logic [XLEN-1:0]    ar_addr;
  bit                 restart;
  bit                 got;
  bit                 snap;
  int                 n_ok;
  int                 n_bad;
  int                 bad_mark;
  int                 n_ar;
  int                 n_xfer;

  fetch_top dut0 (.*);

  tb_imem_axil u_imem (
    .clk     (clk),
    .arst_n  (arst_n),
    .words   (imem_words),
    .araddr  (imem_araddr),
    .arvalid (imem_arvalid),
    .arready (imem_arready),
    .rdata   (imem_rdata),
    .rresp   (imem_rresp),
    .rvalid  (imem_rvalid),
    .rready  (imem_rready)
  );

  always #50 clk = !clk;

  task automatic check_val(input string what, input logic [63:0] got_v, input logic [63:0] exp_v);
    assert (got_v === exp_v) n_ok++;
    else begin
      $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got_v, exp_v);
      n_bad++;
    end
  endtask

  // waits for one issue transfer, sampled at the rising edge
  task automatic wait_transfer(output bit ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < 200) begin
      @(posedge clk);
      if (issue_valid && issue_ready) begin
        ok = 1'b1;
      end
      n++;
    end
    if (!ok) begin
      $display("timeout at %0t: no issue transfer within 200 cycles", $time);
      n_bad++;
    end
  endtask

  task automatic check_transfer(input logic [XLEN-1:0] exp_pc, input bit first);
    int   idx;
    bit   flt;
    row_t r;
    idx = ((exp_pc - RESET_PC) >> 2) & 15;
    flt = exp_pc >= 32'h0000_2000;
    r   = tbl[idx];
    check_val("issue_pc", issue_pc, exp_pc);
    check_val("issue_pc_next", issue_pc_next, exp_pc + 32'd4);
    if (first) begin
      // order keeps counting across a flush
      assert (issue_order > last_ord) n_ok++;
      else begin
        $display("mismatch at %0t: order %0d after flush does not exceed %0d",
                 $time, issue_order, last_ord);
        n_bad++;
      end
    end else begin
      check_val("issue_order", issue_order, last_ord + 64'd1);
    end
    last_ord = issue_order;
    check_val("issue_fault", issue_fault, flt);
    if (!flt) begin
      check_val("issue_instr", issue_instr, r.word);
      check_val("issue_opcode", issue_opcode, r.op);
      check_val("issue_funct3", issue_funct3, r.f3);
      check_val("issue_funct7", issue_funct7, r.f7);
      check_val("issue_imm", issue_imm, r.imm);
      check_val("issue_rs1", issue_rs1, r.rs1);
      check_val("issue_rs2", issue_rs2, r.rs2);
      check_val("issue_rd", issue_rd, r.rd);
    end
  endtask

  // expect a run of in-order transfers from next_pc
  task automatic take_run(input int count);
    for (int k = 0; k < count; k++) begin
      wait_transfer(got);
      if (got) begin
        check_transfer(next_pc, restart);
        restart = 1'b0;
        next_pc = next_pc + 32'd4;
      end
    end
  endtask

  // called right after a rising edge, flush lands on the next one
  task automatic redirect(input logic [XLEN-1:0] new_pc);
    #10;
    issue_ready = 1'b0;
    flush       = 1'b1;
    flush_pc    = new_pc;
    @(posedge clk);
    #10;
    flush       = 1'b0;
    issue_ready = 1'b1;
    next_pc     = new_pc;
    restart     = 1'b1;
  endtask

  task automatic report_test(input string name, input int mark);
    if (n_bad == mark) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, n_bad - mark);
    end
  endtask

  initial begin
    tbl[0]  = '{32'h00500093, 7'h13, 3'd0, 7'h00, 32'h00000005, 5'd0, 5'd5, 5'd1};
    tbl[1]  = '{32'hFFF08113, 7'h13, 3'd0, 7'h7F, 32'hFFFFFFFF, 5'd1, 5'd31, 5'd2};
    tbl[2]  = '{32'h002081B3, 7'h33, 3'd0, 7'h00, 32'h00000000, 5'd1, 5'd2, 5'd3};
    tbl[3]  = '{32'h40218233, 7'h33, 3'd0, 7'h20, 32'h00000000, 5'd3, 5'd2, 5'd4};
    tbl[4]  = '{32'h123452B7, 7'h37, 3'd5, 7'h09, 32'h12345000, 5'd8, 5'd3, 5'd5};
    tbl[5]  = '{32'hFFFFF317, 7'h17, 3'd7, 7'h7F, 32'hFFFFF000, 5'd31, 5'd31, 5'd6};
    tbl[6]  = '{32'h008000EF, 7'h6F, 3'd0, 7'h00, 32'h00000008, 5'd0, 5'd8, 5'd1};
    tbl[7]  = '{32'hFF8FF06F, 7'h6F, 3'd7, 7'h7F, 32'hFFFFF7F8, 5'd31, 5'd24, 5'd0};
    tbl[8]  = '{32'h00C280E7, 7'h67, 3'd0, 7'h00, 32'h0000000C, 5'd5, 5'd12, 5'd1};
    tbl[9]  = '{32'h00208863, 7'h63, 3'd0, 7'h00, 32'h00000010, 5'd1, 5'd2, 5'd16};
    tbl[10] = '{32'hFE419CE3, 7'h63, 3'd1, 7'h7F, 32'hFFFFFFF8, 5'd3, 5'd4, 5'd25};
    tbl[11] = '{32'hFFC12383, 7'h03, 3'd2, 7'h7F, 32'hFFFFFFFC, 5'd2, 5'd28, 5'd7};
    tbl[12] = '{32'h02712223, 7'h23, 3'd2, 7'h01, 32'h00000024, 5'd2, 5'd7, 5'd4};
    tbl[13] = '{32'hFE118FA3, 7'h23, 3'd0, 7'h7F, 32'hFFFFFFFF, 5'd3, 5'd1, 5'd31};
    tbl[14] = '{32'h00000073, 7'h73, 3'd0, 7'h00, 32'h00000000, 5'd0, 5'd0, 5'd0};
    // custom opcode, no immediate format
    tbl[15] = '{32'h0020A00B, 7'h0B, 3'd2, 7'h00, 32'h00000000, 5'd1, 5'd2, 5'd0};
    for (int i = 0; i < 16; i++) begin
      imem_words[i] = tbl[i].word;
    end

    void'($urandom(83382));
    clk         = 1'b0;
    arst_n      = 1'b0;
    flush       = 1'b0;
    flush_pc    = '0;
    issue_ready = 1'b0;
    n_ok        = 0;
    n_bad       = 0;
    last_ord    = '1;
    next_pc     = RESET_PC;
    restart     = 1'b0;
    repeat (8) @(posedge clk);
    #10 arst_n = 1'b1;

    // sequential stream from reset
    bad_mark    = n_bad;
    issue_ready = 1'b1;
    take_run(32);
    report_test("sequential", bad_mark);

    // back-pressure, outputs frozen and fetch stalls
    bad_mark = n_bad;
    #10 issue_ready = 1'b0;
    snap = 1'b0;
    n_ar = 0;
    for (int c = 0; c < 40; c++) begin
      @(posedge clk);
      if (imem_arvalid && imem_arready) begin
        // addresses keep walking by one word
        if (n_ar > 0) begin
          check_val("imem_araddr", imem_araddr, ar_addr + 32'd4);
        end
        ar_addr = imem_araddr;
        n_ar++;
      end
      check_val("imem_rready", imem_rready, 1'b1);
      if (snap) begin
        check_val("held issue_valid", issue_valid, 1'b1);
        check_val("held issue_pc", issue_pc, snap_pc);
        check_val("held issue_order", issue_order, snap_ord);
        check_val("held issue_instr", issue_instr, snap_instr);
      end else if (issue_valid) begin
        snap       = 1'b1;
        snap_pc    = issue_pc;
        snap_ord   = issue_order;
        snap_instr = issue_instr;
      end
    end
    check_val("imem_arvalid after hold", imem_arvalid, 1'b0);
    // one word may move on into the decode register
    assert (n_ar <= IQ_DEPTH + 1) n_ok++;
    else begin
      $display("too many reads accepted under back-pressure: %0d", n_ar);
      n_bad++;
    end
    #10 issue_ready = 1'b1;
    take_run(16);
    report_test("back-pressure", bad_mark);

    // flush with reads in flight
    bad_mark = n_bad;
    take_run(3);
    redirect(RESET_PC + 32'h40);
    take_run(8);
    report_test("flush", bad_mark);

    // stream that runs into the error window
    bad_mark = n_bad;
    redirect(32'h0000_1FF8);
    take_run(6);
    report_test("fetch fault", bad_mark);

    // random consumer stalls
    bad_mark = n_bad;
    redirect(RESET_PC);
    n_xfer = 0;
    for (int c = 0; c < 200; c++) begin
      @(posedge clk);
      if (issue_valid && issue_ready) begin
        check_transfer(next_pc, restart);
        restart = 1'b0;
        next_pc = next_pc + 32'd4;
        n_xfer++;
      end
      #10 issue_ready = 1'($urandom_range(0, 1));
    end
    assert (n_xfer > 0) n_ok++;
    else begin
      $display("no transfer happened during random ready");
      n_bad++;
    end
    report_test("random ready", bad_mark);

    $display("summary: %0d checks ok, %0d errors", n_ok, n_bad);
    if (n_bad == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : tb_fetch_top

//--- fetch_iq.f
source/fetch_pkg.sv
source/iq_ifs.sv
source/fetch_unit.sv
source/instruction_queue.sv
source/rv32_decode.sv
source/fetch_top.sv
tb/tb_imem_axil.sv
tb/tb_fetch_top.sv

//--- run.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch_top \
  -f fetch_iq.f -o sim_fetch_top > build.log 2>&1 \
  && ./obj_dir/sim_fetch_top > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Test failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Test passed" sim.log || { echo "simulation ended without a verdict"; exit 1; }
exit 0
